/* fir_tap_pkg.sv */
`default_nettype none

package fir_tap_pkg;

    ////////////////////////////////////////
    // Operand widths
    ////////////////////////////////////////

    // A and D samples
    localparam int DATA_W = 26;

    // Pre-adder sum keeps the carry bit
    localparam int PREADD_W = DATA_W + 1;

    // Coefficient, as on the B port of the slice
    localparam int COEFF_W = 18;

    // Full-precision product of pre-adder sum and coefficient
    localparam int PRODUCT_W = PREADD_W + COEFF_W;

    // C, PCIN and P
    localparam int ACC_W = 48;

    ////////////////////////////////////////
    // Pipeline depth
    ////////////////////////////////////////

    // A/D register, pre-adder register and multiplier register
    localparam int MULT_STAGES = 3;

    ////////////////////////////////////////
    // Vector types
    ////////////////////////////////////////

    typedef logic signed [DATA_W-1:0]    data_t;
    typedef logic signed [PREADD_W-1:0]  preadd_t;
    typedef logic signed [COEFF_W-1:0]   coeff_t;
    typedef logic signed [PRODUCT_W-1:0] product_t;
    typedef logic signed [ACC_W-1:0]     acc_t;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // One sample pair for the pre-adder
    typedef struct packed {
        data_t a;
        data_t d;
    } tap_sample_t;

    // Coefficient load and update strobes with the new value
    typedef struct packed {
        logic   load;
        logic   update;
        coeff_t coeff;
    } coeff_ctrl_t;

endpackage

`default_nettype wire

/* fir_tap_mult_path.sv */
`default_nettype none

module fir_tap_mult_path
    import fir_tap_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_i,
    input  tap_sample_t sample_i,
    input  coeff_ctrl_t coeff_ctrl_i,
    output product_t    product_o
);

    ////////////////////////////////////////
    // Coefficient registers
    ////////////////////////////////////////

    // First register, written by the load strobe
    coeff_t coeff_load_q;

    // Working register, written by the update strobe
    coeff_t coeff_work_q;

    ////////////////////////////////////////
    // Data pipeline
    ////////////////////////////////////////

    // Stage 1: input samples and the coefficient seen with them
    tap_sample_t sample_q;
    coeff_t      coeff_s1_q;

    // Stage 2: pre-adder sum and its coefficient copy
    preadd_t     preadd_sum;
    preadd_t     preadd_q;
    coeff_t      coeff_s2_q;

    // Stage 3: product
    product_t    product_q;

    // Both strobes may fire together; the working register then
    // picks up what the first register held before this edge
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            coeff_load_q <= '0;
            coeff_work_q <= '0;
        end else begin
            if (coeff_ctrl_i.load) begin
                coeff_load_q <= coeff_ctrl_i.coeff;
            end
            if (coeff_ctrl_i.update) begin
                coeff_work_q <= coeff_load_q;
            end
        end
    end

    // Input register for A and D
    // The working coefficient is sampled on the same edge, so a sample
    // uses the value that stood just before it was captured
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sample_q   <= '0;
            coeff_s1_q <= '0;
        end else begin
            sample_q   <= sample_i;
            coeff_s1_q <= coeff_work_q;
        end
    end

    // Pre-adder, D + A with one bit of growth
    assign preadd_sum = preadd_t'(sample_q.d) + preadd_t'(sample_q.a);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            preadd_q   <= '0;
            coeff_s2_q <= '0;
        end else begin
            preadd_q   <= preadd_sum;
            coeff_s2_q <= coeff_s1_q;
        end
    end

    // Signed multiply at full width, no truncation
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            product_q <= '0;
        end else begin
            product_q <= preadd_q * coeff_s2_q;
        end
    end

    assign product_o = product_q;

endmodule

`default_nettype wire

/* fir_tap_addend_path.sv */
`default_nettype none

module fir_tap_addend_path
    import fir_tap_pkg::*;
(
    input  wire  clk_i,
    input  wire  rst_i,
    input  acc_t c_i,
    output acc_t c_aligned_o
);

    ////////////////////////////////////////
    // C delay line
    ////////////////////////////////////////

    // First entry is the C input register, the rest match the
    // pre-adder and multiplier stages
    acc_t c_pipe_q [MULT_STAGES];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < MULT_STAGES; i++) begin
                c_pipe_q[i] <= '0;
            end
        end else begin
            c_pipe_q[0] <= c_i;
            for (int i = 1; i < MULT_STAGES; i++) begin
                c_pipe_q[i] <= c_pipe_q[i-1];
            end
        end
    end

    // Leaves in the same cycle as the product of its sample
    assign c_aligned_o = c_pipe_q[MULT_STAGES-1];

endmodule

`default_nettype wire

/* fir_tap_post_adder.sv */
`default_nettype none

module fir_tap_post_adder
    import fir_tap_pkg::*;
(
    input  wire      clk_i,
    input  wire      rst_i,
    input  product_t product_i,
    input  acc_t     c_aligned_i,
    input  acc_t     pcin_i,
    output acc_t     p_o
);

    ////////////////////////////////////////
    // Three-input adder
    ////////////////////////////////////////

    acc_t product_ext;
    acc_t sum;
    acc_t p_q;

    // Sign-extend the product up to the accumulator width
    assign product_ext = {{(ACC_W-PRODUCT_W){product_i[PRODUCT_W-1]}}, product_i};

    // PCIN comes in unregistered from the previous tap
    // Carry out of bit 47 is dropped
    assign sum = product_ext + c_aligned_i + pcin_i;

    ////////////////////////////////////////
    // P register
    ////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            p_q <= '0;
        end else begin
            p_q <= sum;
        end
    end

    assign p_o = p_q;

endmodule

`default_nettype wire

/* fir_tap_top.sv */
`default_nettype none

module fir_tap_top
    import fir_tap_pkg::*;
(
    input  wire         clk_i,
    input  wire         rst_i,
    input  tap_sample_t sample_i,
    input  coeff_ctrl_t coeff_ctrl_i,
    input  acc_t        c_i,
    input  acc_t        pcin_i,
    output acc_t        p_o
);

    ////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////

    // Product of (D + A) and the working coefficient
    product_t product;

    // C delayed to line up with the product
    acc_t     c_aligned;

    ////////////////////////////////////////
    // Multiplier path
    ////////////////////////////////////////

    fir_tap_mult_path i_mult_path (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .sample_i     (sample_i),
        .coeff_ctrl_i (coeff_ctrl_i),
        .product_o    (product)
    );

    ////////////////////////////////////////
    // Addend path
    ////////////////////////////////////////

    fir_tap_addend_path i_addend_path (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .c_i         (c_i),
        .c_aligned_o (c_aligned)
    );

    ////////////////////////////////////////
    // Post-adder and P register
    ////////////////////////////////////////

    // PCIN joins here directly, one cycle ahead of P
    fir_tap_post_adder i_post_adder (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .product_i   (product),
        .c_aligned_i (c_aligned),
        .pcin_i      (pcin_i),
        .p_o         (p_o)
    );

endmodule

`default_nettype wire

/* tb_fir_tap_util.svh */
`ifndef TB_FIR_TAP_UTIL_SVH
`define TB_FIR_TAP_UTIL_SVH

////////////////////////////////////////
// Random numbers
////////////////////////////////////////

// LCG state seeded once at time zero
logic [31:0] lcg_state = 32'hcbe56f62;

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic data_t rand_data();
    logic [31:0] r;
    r = next_rand();
    return data_t'(r[31:6]);
endfunction

function automatic coeff_t rand_coeff();
    logic [31:0] r;
    r = next_rand();
    return coeff_t'(r[31:14]);
endfunction

// Full 48-bit range built from two draws
function automatic acc_t rand_acc();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return acc_t'({hi[31:8], lo[31:8]});
endfunction

////////////////////////////////////////
// Reference model
////////////////////////////////////////

// P = (D + A) * B + C + PCIN wrapped to 48 bits
function automatic acc_t expected_p(input data_t a, input data_t d, input coeff_t b,
                                    input acc_t c, input acc_t pcin);
    longint pre_sum;
    longint total;
    pre_sum = longint'(a) + longint'(d);
    total = pre_sum * longint'(b) + longint'(c) + longint'(pcin);
    return acc_t'(total);
endfunction

////////////////////////////////////////
// Compare
////////////////////////////////////////

task automatic check_value(input string name, input acc_t actual, input acc_t expected);
    if (actual !== expected) begin
        fail_run($sformatf("MISMATCH %s: got 0x%012h, expected 0x%012h",
                           name, actual, expected));
    end
endtask

`endif

/* tb_fir_tap.sv */
`default_nettype none

module tb_fir_tap
    import fir_tap_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int DRIVE_DELAY     = 1;
    localparam int RESET_CYCLES    = 16;
    localparam int DRAIN_TIMEOUT   = 20;
    localparam int WATCHDOG_CYCLES = 2000;

    logic        clk_i;
    logic        rst_i;
    tap_sample_t sample_i;
    coeff_ctrl_t coeff_ctrl_i;
    acc_t        c_i;
    acc_t        pcin_i;
    acc_t        p_o;

    logic check_en = 1'b0;

    // Model of the first and working coefficient registers
    coeff_t model_load = '0;
    coeff_t model_work = '0;

    // Samples in flight, and the P values expected edge by edge
    tap_sample_t pend_sample[$];
    coeff_t      pend_coeff[$];
    acc_t        pend_c[$];
    acc_t        exp_q[$];

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "Simulation stopped on first error");
    endtask

    `include "tb_fir_tap_util.svh"

    fir_tap_top i_dut (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .sample_i     (sample_i),
        .coeff_ctrl_i (coeff_ctrl_i),
        .c_i          (c_i),
        .pcin_i       (pcin_i),
        .p_o          (p_o)
    );

    ////////////////////////////////////////
    // Clock and watchdog
    ////////////////////////////////////////

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    initial begin
        #(CLK_PERIOD*WATCHDOG_CYCLES);
        fail_run("Simulation ran past its cycle limit");
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    // Called just after a rising edge; the values set here are sampled
    // at the next edge, and the expected P for that edge is queued
    task automatic drive_cycle(input data_t a, input data_t d, input acc_t c,
                               input acc_t pcin, input logic load, input logic update,
                               input coeff_t coeff);
        tap_sample_t s;
        coeff_ctrl_t ctrl;
        coeff_t      old_load;
        tap_sample_t s_old;
        coeff_t      b_old;
        acc_t        c_old;
        s.a = a;
        s.d = d;
        ctrl.load = load;
        ctrl.update = update;
        ctrl.coeff = coeff;
        sample_i = s;
        coeff_ctrl_i = ctrl;
        c_i = c;
        pcin_i = pcin;
        // Product uses the working coefficient as it stands before this edge
        pend_sample.push_back(s);
        pend_coeff.push_back(model_work);
        pend_c.push_back(c);
        old_load = model_load;
        if (load) begin
            model_load = coeff;
        end
        if (update) begin
            model_work = old_load;
        end
        // The sample from three edges back meets this PCIN
        s_old = pend_sample.pop_front();
        b_old = pend_coeff.pop_front();
        c_old = pend_c.pop_front();
        exp_q.push_back(expected_p(s_old.a, s_old.d, b_old, c_old, pcin));
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic run_random(input int cycles, input logic use_pcin,
                              input logic use_strobes);
        acc_t        pcin;
        logic        load;
        logic        update;
        logic [31:0] r;
        for (int i = 0; i < cycles; i++) begin
            pcin = use_pcin ? rand_acc() : '0;
            load = 1'b0;
            update = 1'b0;
            if (use_strobes) begin
                r = next_rand();
                load = (r[30:28] == 3'd0);
                update = (r[26:24] == 3'd0);
            end
            drive_cycle(rand_data(), rand_data(), rand_acc(), pcin, load, update,
                        rand_coeff());
        end
    endtask

    ////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////

    initial begin : compare_proc
        acc_t exp_val;
        forever begin
            @(negedge clk_i);
            if (check_en) begin
                if (exp_q.size() == 0) begin
                    fail_run("Expected-value queue ran empty while p_o was checked");
                end else begin
                    exp_val = exp_q.pop_front();
                    check_value("p_o", p_o, exp_val);
                end
            end
        end
    end

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin : main_proc
        coeff_t cf_a;
        coeff_t cf_b;
        int     drain_cnt;
        rst_i = 1'b1;
        sample_i = '0;
        coeff_ctrl_i = '0;
        c_i = '0;
        pcin_i = '0;
        // Pipeline holds zeros right after reset
        for (int i = 0; i < MULT_STAGES; i++) begin
            pend_sample.push_back('0);
            pend_coeff.push_back('0);
            pend_c.push_back('0);
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_i = 1'b0;

        // Idle inputs keep P at zero
        drive_cycle('0, '0, '0, '0, 1'b0, 1'b0, '0);
        check_en = 1'b1;
        repeat (8) drive_cycle('0, '0, '0, '0, 1'b0, 1'b0, '0);

        // Load, then update, then a plain stream with PCIN at zero
        cf_a = rand_coeff();
        drive_cycle('0, '0, '0, '0, 1'b1, 1'b0, cf_a);
        drive_cycle('0, '0, '0, '0, 1'b0, 1'b1, '0);
        run_random(40, 1'b0, 1'b0);

        // Random PCIN joins the stream
        run_random(40, 1'b1, 1'b0);

        // Extreme operands so the 48-bit sum wraps
        drive_cycle('0, '0, '0, '0, 1'b1, 1'b0, coeff_t'(18'h1ffff));
        drive_cycle('0, '0, '0, '0, 1'b0, 1'b1, '0);
        drive_cycle(data_t'(26'h1ffffff), data_t'(26'h1ffffff), acc_t'(48'h7fff_ffff_ffff),
                    acc_t'(48'h7fff_ffff_ffff), 1'b0, 1'b0, '0);
        drive_cycle(data_t'(26'h2000000), data_t'(26'h2000000), acc_t'(48'h8000_0000_0000),
                    acc_t'(48'h8000_0000_0000), 1'b1, 1'b0, coeff_t'(18'h20000));
        drive_cycle(data_t'(26'h1ffffff), data_t'(26'h2000000), acc_t'(48'hffff_ffff_ffff),
                    acc_t'(48'h7fff_ffff_ffff), 1'b0, 1'b1, '0);
        drive_cycle(data_t'(26'h2000000), data_t'(26'h2000000), acc_t'(48'h7fff_ffff_ffff),
                    acc_t'(48'h7fff_ffff_ffff), 1'b0, 1'b0, '0);
        run_random(10, 1'b1, 1'b0);

        // Load alone changes nothing until the update
        cf_b = rand_coeff();
        drive_cycle(rand_data(), rand_data(), rand_acc(), '0, 1'b1, 1'b0, cf_b);
        run_random(10, 1'b0, 1'b0);
        drive_cycle(rand_data(), rand_data(), rand_acc(), '0, 1'b0, 1'b1, '0);
        run_random(10, 1'b0, 1'b0);

        // Both strobes on one edge move the old first-register value along
        cf_a = rand_coeff();
        cf_b = rand_coeff();
        drive_cycle(rand_data(), rand_data(), rand_acc(), '0, 1'b1, 1'b0, cf_a);
        run_random(4, 1'b0, 1'b0);
        drive_cycle(rand_data(), rand_data(), rand_acc(), '0, 1'b1, 1'b1, cf_b);
        run_random(8, 1'b0, 1'b0);
        drive_cycle(rand_data(), rand_data(), rand_acc(), '0, 1'b0, 1'b1, '0);
        run_random(8, 1'b0, 1'b0);

        // Long mixed run with strobes scattered through it
        run_random(200, 1'b1, 1'b1);

        // Let the last results come out
        drain_cnt = 0;
        while (exp_q.size() != 0 && drain_cnt < DRAIN_TIMEOUT) begin
            @(posedge clk_i);
            drain_cnt++;
        end
        check_en = 1'b0;
        if (exp_q.size() != 0) begin
            fail_run("Timed out waiting for the last P results");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
fir_tap_pkg.sv
fir_tap_mult_path.sv
fir_tap_addend_path.sv
fir_tap_post_adder.sv
fir_tap_top.sv
tb_fir_tap.sv
